/* divIterStage.sv */
// iteration part of the mantissa divider
// stage counter, four chained non-restoring cells, remainder and quotient registers
`timescale 1ns/1ns
`include "mantDiv_params.svh"

module divIterStage
(
  input  logic                 Clk_CI,
  input  logic                 Rst_RBI,
  input  logic                 StartDly,
  input  mantDivPkg::stageCntT StageLast,
  input  mantDivPkg::mantT     Numerator,
  input  mantDivPkg::mantT     Denominator,
  output logic                 FinalStage,
  output mantDivPkg::quotT     Quotient,
  output logic                 Msc
);

  mantDivPkg::stageCntT stageCnt;
  logic                 runEn;

  mantDivPkg::mantT     numSmp;
  mantDivPkg::mantT     denSmp;
  mantDivPkg::mantT     denHold;
  mantDivPkg::mantT     denEff;
  mantDivPkg::remT      denPos;
  mantDivPkg::remT      denNeg;

  mantDivPkg::remT      remQ;

  mantDivPkg::remT      cellA   [`BITS_PER_CYCLE];
  mantDivPkg::remT      cellSum [`BITS_PER_CYCLE];
  logic [`BITS_PER_CYCLE-1:0] cellSel;
  logic [`BITS_PER_CYCLE-1:0] cellCarry;
  logic [`BITS_PER_CYCLE-1:0] qNibble;

  ////////////////////////////////
  // iteration control
  ////////////////////////////////

  assign runEn      = StartDly | (stageCnt != '0);
  assign FinalStage = ~StartDly & (stageCnt == StageLast);

  always_ff @(posedge Clk_CI, negedge Rst_RBI)
  begin
    if (~Rst_RBI)
    begin
      stageCnt <= '0;
    end
    else if (StartDly)
    begin
      stageCnt <= 3'd1;             // a new start also restarts a running division
    end
    else if (FinalStage)
    begin
      stageCnt <= '0;
    end
    else if (runEn)
    begin
      stageCnt <= stageCnt + 3'd1;
    end
  end

  ////////////////////////////////
  // operands
  ////////////////////////////////

  // sampled with the start edge, the divisor is then kept for the whole run
  always_ff @(posedge Clk_CI)
  begin
    numSmp <= Numerator;
    denSmp <= Denominator;
    if (StartDly)
    begin
      denHold <= denSmp;
    end
  end

  assign denEff = StartDly ? denSmp : denHold;
  assign denPos = {1'b0, denEff};
  assign denNeg = ~denPos;          // +1 comes in as carry

  ////////////////////////////////
  // non-restoring cells
  ////////////////////////////////

  for (genvar k = 0; k < `BITS_PER_CYCLE; k++)
  begin : gCell
    mantDivPkg::remT opB;

    if (k == 0)
    begin : gHead
      // first step after start is always a subtract on the plain numerator
      assign cellA[k]   = StartDly ? {1'b0, numSmp} : {remQ[`MANT_W-1:0], 1'b0};
      assign cellSel[k] = StartDly | Quotient[0];
    end
    else
    begin : gChain
      assign cellA[k]   = {cellSum[k-1][`MANT_W-1:0], 1'b0};   // 2r
      assign cellSel[k] = cellCarry[k-1];
    end

    // subtract while the last remainder was >= 0, else add back
    assign opB = cellSel[k] ? denNeg : denPos;

    // carry out is set exactly when the new remainder is non-negative
    assign {cellCarry[k], cellSum[k]} = {1'b0, cellA[k]} + {1'b0, opB}
                                      + {{(`MANT_W + 1){1'b0}}, cellSel[k]};

    assign qNibble[`BITS_PER_CYCLE-1-k] = cellCarry[k];    // msb first
  end

  ////////////////////////////////
  // remainder and quotient
  ////////////////////////////////

  always_ff @(posedge Clk_CI)
  begin
    if (runEn)
    begin
      remQ     <= cellSum[`BITS_PER_CYCLE-1];
      Quotient <= {Quotient[`MANT_W-1-`BITS_PER_CYCLE:0], qNibble};
    end
  end

  // once idle the head cell works on the stored remainder, its carry is the next bit
  assign Msc = cellCarry[0];

endmodule

/* divOperandIn.sv */
// input side of the mantissa divider
// start delay, precision latch and stage decode, pre-normalization exponent
`timescale 1ns/1ns
`include "mantDiv_params.svh"

module divOperandIn
(
  input  logic                 Clk_CI,
  input  logic                 Rst_RBI,
  input  logic                 DivStart,
  input  mantDivPkg::precT     PrecCtl,
  input  mantDivPkg::expT      ExpNum,
  input  mantDivPkg::expT      ExpDen,
  output logic                 StartDly,
  output mantDivPkg::stageCntT StageLast,
  output mantDivPkg::precT     Prec,
  output mantDivPkg::expResT   ExpResult
);

  logic               precInRange;
  mantDivPkg::expResT expNumSe;
  mantDivPkg::expResT expDenSe;
  mantDivPkg::expResT expPrenorm;

  ////////////////////////////////
  // start strobe
  ////////////////////////////////

  always_ff @(posedge Clk_CI, negedge Rst_RBI)
  begin
    if (~Rst_RBI)
    begin
      StartDly <= 1'b0;
    end
    else
    begin
      StartDly <= DivStart;       // first iteration cycle
    end
  end

  ////////////////////////////////
  // precision control
  ////////////////////////////////

  assign precInRange = (PrecCtl >= mantDivPkg::precT'(`PREC_MIN)) &&
                       (PrecCtl <= mantDivPkg::precT'(`PREC_MAX));

  // unsupported codes run as full single precision
  always_ff @(posedge Clk_CI, negedge Rst_RBI)
  begin
    if (~Rst_RBI)
    begin
      Prec <= mantDivPkg::precT'(`PREC_MAX);
    end
    else if (DivStart)
    begin
      if (precInRange)
      begin
        Prec <= PrecCtl;
      end
      else
      begin
        Prec <= mantDivPkg::precT'(`PREC_MAX);
      end
    end
  end

  // one nibble per stage, p+2 quotient bits needed incl. round bit
  always_comb
  begin
    case (Prec) inside
      [5'd8:5'd11]:  StageLast = 3'd2;   // 12 bits
      [5'd12:5'd15]: StageLast = 3'd3;   // 16 bits
      [5'd16:5'd19]: StageLast = 3'd4;   // 20 bits
      [5'd20:5'd23]: StageLast = 3'd5;   // 24 bits
      default:       StageLast = 3'd5;
    endcase
  end

  ////////////////////////////////
  // exponent
  ////////////////////////////////

  assign expNumSe = {ExpNum[`EXP_W-1], ExpNum};
  assign expDenSe = {ExpDen[`EXP_W-1], ExpDen};

  // e_num - e_den + bias, normalization happens downstream
  assign expPrenorm = expNumSe - expDenSe + mantDivPkg::expResT'(`EXP_BIAS);

  always_ff @(posedge Clk_CI)
  begin
    if (DivStart)
    begin
      ExpResult <= expPrenorm;
    end
  end

endmodule

/* divResultOut.sv */
// output side of the mantissa divider
// precision truncation, single rounding step, ready and done flags
`timescale 1ns/1ns
`include "mantDiv_params.svh"

module divResultOut
(
  input  logic             Clk_CI,
  input  logic             Rst_RBI,
  input  logic             DivStart,
  input  logic             FinalStage,
  input  mantDivPkg::precT Prec,
  input  mantDivPkg::quotT Quotient,
  input  logic             Msc,
  output mantDivPkg::mantT MantResult,
  output logic             Ready,
  output logic             Done
);

  logic [4:0]       alignShift;
  logic [4:0]       padBits;
  logic [`MANT_W:0] alignedQ;
  mantDivPkg::mantT keepMask;
  mantDivPkg::mantT truncMant;
  logic             roundBit;
  logic [`MANT_W:0] roundSum;

  ////////////////////////////////
  // precision select
  ////////////////////////////////

  // each precision group fills one more nibble, the rest of the word stays unused
  assign alignShift = 5'(`MANT_W - `BITS_PER_CYCLE) - {Prec[4:2], 2'b00};

  // number of zero-padded fraction bits, 23 - p
  assign padBits = 5'(`PREC_MAX) - Prec;

  // q1 at the top, Msc just below the last computed bit
  assign alignedQ = {Quotient, Msc} << alignShift;

  assign keepMask  = {`MANT_W{1'b1}} << padBits;
  assign truncMant = alignedQ[`MANT_W:1] & keepMask;   // top p+1 bits, left aligned

  assign roundBit = alignedQ[padBits];                 // quotient bit p+2

  ////////////////////////////////
  // rounding correction
  ////////////////////////////////

  assign roundSum = {1'b0, truncMant} + ({{`MANT_W{1'b0}}, roundBit} << padBits);

  // skip the increment when it would carry out of p+1 bits
  assign MantResult = roundSum[`MANT_W] ? truncMant : roundSum[`MANT_W-1:0];

  ////////////////////////////////
  // handshake flags
  ////////////////////////////////

  always_ff @(posedge Clk_CI, negedge Rst_RBI)
  begin
    if (~Rst_RBI)
    begin
      Done <= 1'b0;
    end
    else if (DivStart)
    begin
      Done <= 1'b0;
    end
    else
    begin
      Done <= FinalStage;           // one cycle pulse
    end
  end

  always_ff @(posedge Clk_CI, negedge Rst_RBI)
  begin
    if (~Rst_RBI)
    begin
      Ready <= 1'b1;
    end
    else if (DivStart)
    begin
      Ready <= 1'b0;
    end
    else if (FinalStage)
    begin
      Ready <= 1'b1;                // rises together with Done
    end
  end

endmodule

/* mantDivPkg.sv */
// shared data types of the mantissa divider

`include "mantDiv_params.svh"

package mantDivPkg;

  ////////////////////////////////
  // datapath
  ////////////////////////////////

  // significand in, mantissa result out
  typedef logic [`MANT_W-1:0] mantT;

  // partial remainder, one guard bit above the significand
  typedef logic [`MANT_W:0]   remT;

  // quotient shift register
  typedef logic [`MANT_W-1:0] quotT;

  ////////////////////////////////
  // exponent and control
  ////////////////////////////////

  typedef logic [`EXP_W-1:0]  expT;
  typedef logic [`EXP_W:0]    expResT;     // two's complement, one extra bit

  typedef logic [`PREC_W-1:0] precT;

  // iteration counter, 0..5
  typedef logic [2:0]         stageCntT;

endpackage

/* mantDivTb.sv */
// directed testbench for the mantissa divider
// LCG, reference model, compare tasks and the tests
`timescale 1ns/1ns
`include "mantDiv_params.svh"

module mantDivTb;

  logic               Clk_CI = 1'b0;
  logic               Rst_RBI;
  logic               DivStart;
  mantDivPkg::precT   PrecCtl;
  mantDivPkg::mantT   Numerator;
  mantDivPkg::mantT   Denominator;
  mantDivPkg::expT    ExpNum;
  mantDivPkg::expT    ExpDen;
  mantDivPkg::mantT   MantResult;
  mantDivPkg::expResT ExpResult;
  logic               Ready;
  logic               Done;

  int          errCnt    = 0;
  int          passTests = 0;
  int          failTests = 0;
  logic [31:0] lcgState  = 32'd25;

  mantDivTop UUT (.*);

  bind mantDivTop mantDiv_asserts uAsserts
  (
    .Clk_CI   (Clk_CI),
    .Rst_RBI  (Rst_RBI),
    .DivStart (DivStart),
    .Ready    (Ready),
    .Done     (Done)
  );

  always #20 Clk_CI = ~Clk_CI;     // 40 ns period

  //////////////////////////////
  // stimulus and reference model
  //////////////////////////////

  function automatic logic [31:0] nextRand();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  function automatic mantDivPkg::mantT randMant();
    logic [31:0] r;
    r = nextRand();
    return {1'b1, r[30:8]};        // hidden bit set
  endfunction

  // floor(n*2^p/d) plus next quotient bit, unless that leaves p+1 bits
  function automatic mantDivPkg::mantT modelMant(int prec, mantDivPkg::mantT n,
                                                 mantDivPkg::mantT d);
    int              p;
    longint unsigned num;
    longint unsigned den;
    longint unsigned r;
    longint unsigned t;
    p   = (prec < `PREC_MIN || prec > `PREC_MAX) ? `PREC_MAX : prec;
    num = 64'(n);
    den = 64'(d);
    r   = (num << p) / den;
    t   = (num << (p + 1)) / den;
    if (r + (t & 64'd1) < (64'd1 << (p + 1)))
    begin
      r = r + (t & 64'd1);
    end
    return mantDivPkg::mantT'(r << (`PREC_MAX - p));
  endfunction

  // exponents sign extended, then difference plus bias
  function automatic mantDivPkg::expResT modelExp(mantDivPkg::expT en, mantDivPkg::expT ed);
    int a;
    int b;
    a = $signed(en);
    b = $signed(ed);
    return mantDivPkg::expResT'(a - b + `EXP_BIAS);
  endfunction

  //////////////////////////////
  // compare tasks
  //////////////////////////////

  task automatic checkMant(string name, mantDivPkg::mantT expVal, mantDivPkg::mantT actVal);
    if (actVal !== expVal)
    begin
      $display("Fail at %0t ns: %s expected %h, got %h", $time, name, expVal, actVal);
      errCnt++;
    end
  endtask

  task automatic checkExp(string name, mantDivPkg::expResT expVal,
                          mantDivPkg::expResT actVal);
    if (actVal !== expVal)
    begin
      $display("Fail at %0t ns: %s expected %h, got %h", $time, name, expVal, actVal);
      errCnt++;
    end
  endtask

  task automatic checkFlag(string name, logic expVal, logic actVal);
    if (actVal !== expVal)
    begin
      $display("Fail at %0t ns: %s expected %b, got %b", $time, name, expVal, actVal);
      errCnt++;
    end
  endtask

  task automatic checkEdges(string name, int expVal, int actVal);
    if (actVal != expVal)
    begin
      $display("Fail at %0t ns: %s expected %0d, got %0d", $time, name, expVal, actVal);
      errCnt++;
    end
  endtask

  task automatic reportTest(string name, int errStart);
    if (errCnt == errStart)
    begin
      $display("%s: pass", name);
      passTests++;
    end
    else
    begin
      $display("%s: %0d errors", name, errCnt - errStart);
      failTests++;
    end
  endtask

  // one division, Done awaited with timeout, results against the model
  task automatic runDiv(mantDivPkg::precT p, mantDivPkg::mantT n, mantDivPkg::mantT d,
                        mantDivPkg::expT en, mantDivPkg::expT ed, output int edges);
    int k;
    edges = 0;
    k     = 1;
    @(posedge Clk_CI);
    #2;
    DivStart    = 1'b1;
    PrecCtl     = p;
    Numerator   = n;
    Denominator = d;
    ExpNum      = en;
    ExpDen      = ed;
    @(posedge Clk_CI);             // start edge
    #2;
    DivStart = 1'b0;
    while (edges == 0 && k <= 20)
    begin
      @(posedge Clk_CI);
      #1;
      if (Done)
      begin
        edges = k + 1;             // sampled high at the following edge
      end
      else
      begin
        checkFlag("Ready", 1'b0, Ready);
      end
      k++;
    end
    if (edges == 0)
    begin
      $display("Timeout: no Done within 20 cycles of the start (precision %0d)", p);
      errCnt++;
    end
    else
    begin
      checkFlag("Ready", 1'b1, Ready);
      checkMant("MantResult", modelMant(int'(p), n, d), MantResult);
      checkExp("ExpResult", modelExp(en, ed), ExpResult);
    end
  endtask

  //////////////////////////////
  // tests
  //////////////////////////////

  task automatic testReset();
    int e0;
    e0 = errCnt;
    checkFlag("Ready", 1'b1, Ready);
    checkFlag("Done", 1'b0, Done);
    reportTest("reset state", e0);
  endtask

  task automatic testDirected();
    int e0;
    int edges;
    e0 = errCnt;
    runDiv(5'd23, 24'hC00000, 24'hC00000, 9'd127, 9'd127, edges);
    checkMant("MantResult", 24'h800000, MantResult);     // N = D is exactly 1.0
    runDiv(5'd23, 24'h800000, 24'hFFFFFF, 9'd130, 9'd100, edges);
    runDiv(5'd23, 24'hABCDEF, 24'h800000, 9'd1, 9'd2, edges);
    reportTest("directed precision 23", e0);
  endtask

  task automatic testLatency();
    int e0;
    int edges;
    int precList [5] = '{8, 12, 16, 20, 23};
    int expEdges [5] = '{4, 5, 6, 7, 7};
    e0 = errCnt;
    for (int i = 0; i < 5; i++)
    begin
      runDiv(mantDivPkg::precT'(precList[i]), randMant(), randMant(), 9'd0, 9'd0, edges);
      checkEdges("Done latency", expEdges[i], edges);
    end
    reportTest("latency per precision group", e0);
  endtask

  task automatic testRandom();
    int               e0;
    int               edges;
    logic [31:0]      r;
    mantDivPkg::mantT lowMask;
    e0 = errCnt;
    for (int p = `PREC_MIN; p <= `PREC_MAX; p++)
    begin
      lowMask = (24'd1 << (`PREC_MAX - p)) - 24'd1;
      for (int j = 0; j < 4; j++)
      begin
        r = nextRand();
        runDiv(mantDivPkg::precT'(p), randMant(), randMant(), r[8:0], r[17:9], edges);
        checkMant("MantResult low bits", '0, MantResult & lowMask);
      end
    end
    // unsupported code runs at full precision
    runDiv(5'd3, randMant(), randMant(), 9'd0, 9'd0, edges);
    reportTest("random operands", e0);
  endtask

  task automatic testRounding();
    int               e0;
    int               edges;
    mantDivPkg::mantT d;
    int               precList [4] = '{8, 13, 19, 23};
    e0 = errCnt;
    for (int i = 0; i < 4; i++)
    begin
      d = randMant();
      runDiv(mantDivPkg::precT'(precList[i]), d - 24'd1, d, 9'd5, 9'd5, edges);
      // quotient just below 2, increment would overflow
      runDiv(mantDivPkg::precT'(precList[i]), 24'hFFFFFF, 24'h800000, 9'd5, 9'd5, edges);
    end
    runDiv(5'd23, 24'hC00000, 24'h900000, 9'd10, 9'd200, edges);
    runDiv(5'd23, 24'hC00000, 24'h900000, 9'd255, 9'd0, edges);
    runDiv(5'd23, 24'hC00000, 24'h900000, 9'd0, 9'd255, edges);
    reportTest("rounding overflow and exponent range", e0);
  endtask

  initial
  begin
    Rst_RBI     = 1'b0;
    DivStart    = 1'b0;
    PrecCtl     = '0;
    Numerator   = '0;
    Denominator = '0;
    ExpNum      = '0;
    ExpDen      = '0;
    repeat (8) @(posedge Clk_CI);
    #2;
    Rst_RBI = 1'b1;

    testReset();
    testDirected();
    testLatency();
    testRandom();
    testRounding();

    $display("passing tests %0d, failing tests %0d, errors %0d", passTests, failTests, errCnt);
    if (errCnt == 0)
    begin
      $display("Test completed successfully");
    end
    else
    begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* mantDivTop.f */
+incdir+.
mantDivPkg.sv
divOperandIn.sv
divIterStage.sv
divResultOut.sv
mantDivTop.sv
mantDiv_asserts.sv
mantDivTb.sv

/* mantDivTop.sv */
// top level of the mantissa divider
// operand input, iteration and result output connected by wires
`timescale 1ns/1ns
`include "mantDiv_params.svh"

module mantDivTop
(
  input  logic                 Clk_CI,
  input  logic                 Rst_RBI,
  input  logic                 DivStart,
  input  mantDivPkg::precT     PrecCtl,
  input  mantDivPkg::mantT     Numerator,
  input  mantDivPkg::mantT     Denominator,
  input  mantDivPkg::expT      ExpNum,
  input  mantDivPkg::expT      ExpDen,
  output mantDivPkg::mantT     MantResult,
  output mantDivPkg::expResT   ExpResult,
  output logic                 Ready,
  output logic                 Done
);

  logic                 startDly;
  mantDivPkg::stageCntT stageLast;
  mantDivPkg::precT     prec;
  logic                 finalStage;
  mantDivPkg::quotT     quotient;
  logic                 msc;

  // start, precision and exponent
  divOperandIn uOperandIn
  (
    .Clk_CI    (Clk_CI),
    .Rst_RBI   (Rst_RBI),
    .DivStart  (DivStart),
    .PrecCtl   (PrecCtl),
    .ExpNum    (ExpNum),
    .ExpDen    (ExpDen),
    .StartDly  (startDly),
    .StageLast (stageLast),
    .Prec      (prec),
    .ExpResult (ExpResult)
  );

  // 4 quotient bits per clock
  divIterStage uIterStage
  (
    .Clk_CI      (Clk_CI),
    .Rst_RBI     (Rst_RBI),
    .StartDly    (startDly),
    .StageLast   (stageLast),
    .Numerator   (Numerator),
    .Denominator (Denominator),
    .FinalStage  (finalStage),
    .Quotient    (quotient),
    .Msc         (msc)
  );

  divResultOut uResultOut
  (
    .Clk_CI     (Clk_CI),
    .Rst_RBI    (Rst_RBI),
    .DivStart   (DivStart),
    .FinalStage (finalStage),
    .Prec       (prec),
    .Quotient   (quotient),
    .Msc        (msc),
    .MantResult (MantResult),
    .Ready      (Ready),
    .Done       (Done)
  );

endmodule

/* mantDiv_asserts.sv */
// concurrent checks on the start, ready and done flags of the divider
`timescale 1ns/1ns

module mantDiv_asserts
(
  input logic Clk_CI,
  input logic Rst_RBI,
  input logic DivStart,
  input logic Ready,
  input logic Done
);

  // done is a single cycle pulse
  property donePulse;
    @(posedge Clk_CI) disable iff (~Rst_RBI)
      Done |=> ~Done;
  endproperty

  property doneWithReady;
    @(posedge Clk_CI) disable iff (~Rst_RBI)
      Done |-> Ready;
  endproperty

  // an accepted start makes the divider busy
  property startClearsReady;
    @(posedge Clk_CI) disable iff (~Rst_RBI)
      (DivStart && Ready) |=> ~Ready;
  endproperty

  aDonePulse: assert property (donePulse)
    else $error("Done stayed high for two cycles");

  aDoneWithReady: assert property (doneWithReady)
    else $error("Done high while Ready is low");

  aStartClearsReady: assert property (startClearsReady)
    else $error("Ready still high one edge after DivStart");

endmodule

/* mantDiv_params.svh */
// width, bias and precision range macros for the mantissa divider

`ifndef MANT_DIV_PARAMS_SVH
`define MANT_DIV_PARAMS_SVH

// significand incl. hidden bit
`define MANT_W          24
// input exponent
`define EXP_W           9

// precision control, fraction bits kept
`define PREC_W          5
`define PREC_MIN        8
`define PREC_MAX        23

// cells per iteration, one quotient nibble per clock
`define BITS_PER_CYCLE  4

`define EXP_BIAS        127

`endif

/* runSim.sh */
#!/bin/bash
# build and run the mantissa divider testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --assert -Wno-fatal --top-module mantDivTb -f mantDivTop.f \
  && ./obj_dir/VmantDivTb > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation aborted"; exit 1; }

cat sim.log
grep -q "Test failed" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }
